// ==== dv/chart_stim.mem ====
// Chart words at 0x00: bit 15 ends the chart, bits 3..0 are lanes 3..0
// Key events: count at 0x10, then frame, key mask, expected hit mask; totals at 0x30
@00
0003  // both missed at frame 8 while the score is 0
0002  // missed at frame 12
0004  // hit at frame 14
0009  // lane 0 hit at frame 19, lane 3 missed at frame 20
0000  // empty step
0006  // both hit at frame 26
000F  // lanes 0 and 1 hit at frame 30, lanes 2 and 3 missed at frame 32
8000  // end of chart
@10
0006  // number of key events
000A 0008 0000  // lane 3 is empty
000D 0004 0000  // arrow still above the window
000E 0004 0004
0013 0001 0001
001A 0006 0006
001E 0003 0003
@30
0006  // expected hits
0006  // expected misses
002D  // expected final score

// ==== src.f ====
logic/rhythm_pkg.sv
logic/chart_fetch.sv
logic/note_track.sv
logic/score_keeper.sv
logic/seg7_score_display.sv
logic/rhythm_top.sv
dv/rhythm_tb.sv

// ==== Makefile ====
TOP := rhythm_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== dv/rhythm_tb.sv ====
// Testbench with clock, reset, SRAM model, frame ticks, key schedule, checks and timeout
`default_nettype none

module rhythm_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import rhythm_pkg::*;

	// Stim file sections
	localparam int KEY_BASE    = 'h10;
	localparam int EXP_BASE    = 'h30;
	localparam int CHART_SLOTS = 16;
	localparam int FRAME_CYC   = 16;

	logic                   Clk = 1'b0;
	logic                   arst_n;
	logic                   start;
	logic                   frame_tick;
	lane_mask_t             keys;
	logic [SRAM_DATA_W-1:0] sram_dq;
	logic [SRAM_ADDR_W-1:0] sram_addr;
	sram_ctrl_t             sram_ctrl;
	seg_digits_t            hex;
	logic [SCORE_W-1:0]     score;
	judge_t                 judge;
	logic                   chart_done;

	// Chart image, key events and expected totals
	logic [15:0]      stim_mem [0:63];
	// Active-low digit patterns, gfedcba
	logic [SEG_W-1:0] seg_ref [0:15];

	int                 error_count;
	int                 check_count;
	int                 cycle_count;
	int                 cycle_limit;
	int                 frame_num;
	int                 chart_words;
	int                 key_count;
	int                 key_idx;
	int                 reads_seen;
	int                 oe_low_cnt;
	int                 hit_total;
	int                 miss_total;
	int                 press_pulses;
	lane_mask_t         press_hits;
	logic               prev_oe_n;
	logic [SCORE_W-1:0] prev_score;

	// SRAM model, idle bus reads as all ones
	assign sram_dq = (!sram_ctrl.ce_n && !sram_ctrl.oe_n && sram_addr < SRAM_ADDR_W'(CHART_SLOTS))
		? stim_mem[sram_addr[3:0]] : '1;

	rhythm_top dut_i (
		.Clk        (Clk),
		.arst_n     (arst_n),
		.start      (start),
		.frame_tick (frame_tick),
		.keys       (keys),
		.sram_dq    (sram_dq),
		.sram_addr  (sram_addr),
		.sram_ctrl  (sram_ctrl),
		.hex        (hex),
		.score      (score),
		.judge      (judge),
		.chart_done (chart_done)
	);

	always #4 Clk = ~Clk;

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h (frame %0d)", name, actual, expected,
				frame_num);
		end
	endtask

	// Every digit against the table entry of its nibble
	task automatic check_hex();
		for (int d = 0; d < NUM_DIGITS; d++) begin
			check_value($sformatf("hex[%0d]", d), 32'(hex[d]), 32'(seg_ref[score[d*4 +: 4]]));
		end
	endtask

	// Miss must come TRACK_DEPTH frames after a chart step that had this lane
	task automatic check_miss(input int lane);
		int age;
		int step;
		age  = frame_num - TRACK_DEPTH;
		step = (age < 0) ? 0 : age / STEP_FRAMES;
		check_value($sformatf("judge.miss[%0d] frame offset", lane), 32'(age % STEP_FRAMES), 0);
		check_value($sformatf("judge.miss[%0d] chart bit", lane),
			32'(stim_mem[step & 15][lane]), 1);
	endtask

	// One frame, tick first, scheduled press in the middle
	task automatic run_frame();
		lane_mask_t exp_hit;
		@(posedge Clk);
		#1;
		frame_tick = 1'b1;
		frame_num++;
		@(posedge Clk);
		#1;
		frame_tick = 1'b0;
		repeat (6) @(posedge Clk);
		#1;
		if (key_idx < key_count && int'(stim_mem[KEY_BASE + 1 + 3*key_idx]) == frame_num) begin
			exp_hit      = stim_mem[KEY_BASE + 3 + 3*key_idx][NUM_LANES-1:0];
			press_hits   = '0;
			press_pulses = 0;
			keys         = stim_mem[KEY_BASE + 2 + 3*key_idx][NUM_LANES-1:0];
			repeat (4) @(posedge Clk);
			#1;
			keys = '0;
			repeat (4) @(posedge Clk);
			check_value("judge.hit lanes", 32'(press_hits), 32'(exp_hit));
			check_value("judge.hit pulses", 32'(press_pulses), 32'($countones(exp_hit)));
			key_idx++;
		end else begin
			repeat (8) @(posedge Clk);
		end
	endtask

	// ========================================
	// Monitor, sampled mid-cycle
	// ========================================

	always @(negedge Clk) begin
		if (arst_n) begin
			for (int l = 0; l < NUM_LANES; l++) begin
				if (judge.hit[l]) begin
					hit_total++;
					press_pulses++;
					press_hits[l] = 1'b1;
				end
				if (judge.miss[l]) begin
					miss_total++;
					check_miss(l);
				end
			end
			// Read start, address and pacing
			if (!sram_ctrl.oe_n && prev_oe_n) begin
				check_value("sram_addr", 32'(sram_addr), 32'(reads_seen));
				check_value("read start frame", 32'(frame_num), 32'(reads_seen * STEP_FRAMES));
				check_value("sram_ctrl.ce_n", 32'(sram_ctrl.ce_n), 0);
				reads_seen++;
				oe_low_cnt = 1;
			end else if (!sram_ctrl.oe_n) begin
				check_value("sram_addr held", 32'(sram_addr), 32'(reads_seen - 1));
				oe_low_cnt++;
			end else if (!prev_oe_n) begin
				check_value("sram_ctrl.oe_n low cycles", 32'(oe_low_cnt), 32'(SRAM_WAIT));
			end
			if (score !== prev_score) begin
				check_hex();
			end
			prev_score = score;
			prev_oe_n  = sram_ctrl.oe_n;
		end
	end

	// Run length limit
	always @(posedge Clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		arst_n       = 1'b0;
		start        = 1'b0;
		frame_tick   = 1'b0;
		keys         = '0;
		error_count  = 0;
		check_count  = 0;
		cycle_count  = 0;
		frame_num    = 0;
		key_idx      = 0;
		reads_seen   = 0;
		oe_low_cnt   = 0;
		hit_total    = 0;
		miss_total   = 0;
		press_pulses = 0;
		press_hits   = '0;
		prev_oe_n    = 1'b1;
		prev_score   = '0;
		seg_ref = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
		$readmemh("dv/chart_stim.mem", stim_mem);
		// Chart length up to and including the end word
		chart_words = 0;
		for (int i = CHART_SLOTS - 1; i >= 0; i--) begin
			if (stim_mem[i][END_BIT] === 1'b1) begin
				chart_words = i + 1;
			end
		end
		if (chart_words == 0) begin
			$display("The stim file holds no end-of-chart word");
			error_count++;
		end
		key_count   = int'(stim_mem[KEY_BASE]);
		cycle_limit = (chart_words * STEP_FRAMES + TRACK_DEPTH + 4) * FRAME_CYC;

		repeat (5) @(posedge Clk);
		#1;
		arst_n = 1'b1;
		@(negedge Clk);
		check_value("sram_ctrl.oe_n", 32'(sram_ctrl.oe_n), 1);
		check_value("sram_ctrl.ce_n", 32'(sram_ctrl.ce_n), 1);
		check_value("sram_ctrl.we_n", 32'(sram_ctrl.we_n), 1);
		check_value("sram_ctrl.ub_n", 32'(sram_ctrl.ub_n), 0);
		check_value("sram_ctrl.lb_n", 32'(sram_ctrl.lb_n), 0);
		check_value("judge", 32'(judge), 0);
		check_value("score", 32'(score), 0);
		check_value("chart_done", 32'(chart_done), 0);
		for (int d = 0; d < NUM_DIGITS; d++) begin
			check_value($sformatf("hex[%0d]", d), 32'(hex[d]), 32'(seg_ref[0]));
		end

		// Start reads word 0 at frame 0
		@(posedge Clk);
		#1;
		start = 1'b1;
		@(posedge Clk);
		#1;
		start = 1'b0;
		// Word 0 arrows enter before the first frame tick
		repeat (SRAM_WAIT + 2) @(posedge Clk);
		while (chart_done !== 1'b1) begin
			run_frame();
		end
		// Let the last arrows fall off
		repeat (TRACK_DEPTH) run_frame();
		repeat (2) @(posedge Clk);

		check_value("chart_done", 32'(chart_done), 1);
		check_value("sram_addr", 32'(sram_addr), 32'(chart_words - 1));
		check_value("sram reads", 32'(reads_seen), 32'(chart_words));
		check_value("key events used", 32'(key_idx), 32'(key_count));
		check_value("judge.hit total", 32'(hit_total), 32'(stim_mem[EXP_BASE]));
		check_value("judge.miss total", 32'(miss_total), 32'(stim_mem[EXP_BASE + 1]));
		check_value("score", 32'(score), 32'(stim_mem[EXP_BASE + 2]));

		$display("Checks: %0d  errors: %0d  hits: %0d  misses: %0d", check_count, error_count,
			hit_total, miss_total);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/rhythm_top.sv ====
// Game core top level, chart fetcher, arrow lanes, score and hex display
`default_nettype none

module rhythm_top (
	input  logic                               Clk,
	input  logic                               arst_n,
	// Game start, one cycle
	input  logic                               start,
	// Vertical sync strobe, one cycle per frame
	input  logic                               frame_tick,
	// Lane key levels, 1 is pressed
	input  rhythm_pkg::lane_mask_t             keys,
	// Chart SRAM
	input  logic [rhythm_pkg::SRAM_DATA_W-1:0] sram_dq,
	output logic [rhythm_pkg::SRAM_ADDR_W-1:0] sram_addr,
	output rhythm_pkg::sram_ctrl_t             sram_ctrl,
	// Score display
	output rhythm_pkg::seg_digits_t            hex,
	output logic [rhythm_pkg::SCORE_W-1:0]     score,
	// Hit and miss lane indicators
	output rhythm_pkg::judge_t                 judge,
	output logic                               chart_done
);
	import rhythm_pkg::*;

	// ========================================
	// Fetcher to lanes
	// ========================================

	lane_mask_t arrows;
	logic       arrows_valid;

	chart_fetch chart_fetch_i (
		.Clk          (Clk),
		.arst_n       (arst_n),
		.start        (start),
		.frame_tick   (frame_tick),
		.sram_dq      (sram_dq),
		.sram_addr    (sram_addr),
		.sram_ctrl    (sram_ctrl),
		.arrows       (arrows),
		.arrows_valid (arrows_valid),
		.chart_done   (chart_done)
	);

	// Scrolling and judgement
	note_track note_track_i (
		.Clk          (Clk),
		.arst_n       (arst_n),
		.frame_tick   (frame_tick),
		.arrows       (arrows),
		.arrows_valid (arrows_valid),
		.keys         (keys),
		.judge        (judge)
	);

	// ========================================
	// Score path
	// ========================================

	score_keeper score_keeper_i (
		.Clk    (Clk),
		.arst_n (arst_n),
		.judge  (judge),
		.score  (score)
	);

	// Combinational, follows the score register
	seg7_score_display seg7_score_display_i (
		.score (score),
		.hex   (hex)
	);

endmodule

`default_nettype wire

// ==== logic/seg7_score_display.sv ====
// Hex to seven-segment decoding of the four score digits
`default_nettype none

module seg7_score_display (
	input  logic [rhythm_pkg::SCORE_W-1:0] score,
	output rhythm_pkg::seg_digits_t        hex
);
	import rhythm_pkg::*;

	// Active-low segments, bit order gfedcba
	function automatic logic [SEG_W-1:0] seg_lut(input logic [3:0] nib);
		logic [SEG_W-1:0] seg;
		unique case (nib)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b0000011;
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001;
			4'hE: seg = 7'b0000110;
			4'hF: seg = 7'b0001110;
			default: seg = 7'b1111111;
		endcase
		return seg;
	endfunction

	// Same table for every nibble
	always_comb begin
		for (int d = 0; d < NUM_DIGITS; d++) begin
			hex[d] = seg_lut(score[d*4 +: 4]);
		end
	end

endmodule

`default_nettype wire

// ==== logic/score_keeper.sv ====
// Saturating score accumulator driven by hit and miss pulses
`default_nettype none

module score_keeper (
	input  logic                           Clk,
	input  logic                           arst_n,
	input  rhythm_pkg::judge_t             judge,
	output logic [rhythm_pkg::SCORE_W-1:0] score
);
	import rhythm_pkg::*;

	logic [LANE_CNT_W-1:0]  n_hit;
	logic [LANE_CNT_W-1:0]  n_miss;
	logic [SCORE_SUM_W-1:0] gain;
	logic [SCORE_SUM_W-1:0] loss;
	logic [SCORE_SUM_W-1:0] total;
	logic [SCORE_W-1:0]     score_d;

	always_comb begin
		n_hit  = '0;
		n_miss = '0;
		// Several lanes can judge in the same cycle
		for (int l = 0; l < NUM_LANES; l++) begin
			n_hit  = n_hit + LANE_CNT_W'(judge.hit[l]);
			n_miss = n_miss + LANE_CNT_W'(judge.miss[l]);
		end
		gain  = SCORE_SUM_W'(n_hit) * SCORE_SUM_W'(HIT_POINTS);
		loss  = SCORE_SUM_W'(n_miss) * SCORE_SUM_W'(MISS_POINTS);
		total = SCORE_SUM_W'(score) + gain;
		// Floor at zero, clamp at all ones
		if (total <= loss) begin
			score_d = '0;
		end else if ((total - loss) > SCORE_SUM_W'(SCORE_MAX)) begin
			score_d = SCORE_MAX;
		end else begin
			score_d = SCORE_W'(total - loss);
		end
	end

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			score <= '0;
		end else begin
			score <= score_d;
		end
	end

endmodule

`default_nettype wire

// ==== logic/note_track.sv ====
// Arrow lanes with frame scrolling, key edge detection and the hit/miss judge
`default_nettype none

module note_track (
	input  logic                   Clk,
	input  logic                   arst_n,
	input  logic                   frame_tick,
	input  rhythm_pkg::lane_mask_t arrows,
	input  logic                   arrows_valid,
	input  rhythm_pkg::lane_mask_t keys,
	output rhythm_pkg::judge_t     judge
);
	import rhythm_pkg::*;

	// Occupancy per lane, bit 0 is the top position
	logic [NUM_LANES-1:0][TRACK_DEPTH-1:0] track;
	logic [NUM_LANES-1:0][TRACK_DEPTH-1:0] track_d;
	// Arrow removed by a press
	logic [NUM_LANES-1:0][TRACK_DEPTH-1:0] clr_mask;
	// Occupancy after the press is applied
	logic [NUM_LANES-1:0][TRACK_DEPTH-1:0] kept;

	lane_mask_t keys_q;
	lane_mask_t keys_qq;
	lane_mask_t rise;
	lane_mask_t hit_d;
	lane_mask_t miss_d;

	// Deepest occupied position inside the window, one-hot
	function automatic logic [TRACK_DEPTH-1:0] deepest_hit(
		input logic [TRACK_DEPTH-1:0] occ
	);
		logic [TRACK_DEPTH-1:0] sel;
		logic                   found;
		sel   = '0;
		found = 1'b0;
		// Scan upward from the bottom
		for (int p = TRACK_DEPTH - 1; p >= TRACK_DEPTH - HIT_WINDOW; p--) begin
			if (occ[p] && !found) begin
				sel[p] = 1'b1;
				found  = 1'b1;
			end
		end
		return sel;
	endfunction

	// ========================================
	// Key edge detection
	// ========================================

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			keys_q  <= '0;
			keys_qq <= '0;
		end else begin
			keys_q  <= keys;
			keys_qq <= keys_q;
		end
	end

	// Press seen one cycle after the level rises
	assign rise = keys_q & ~keys_qq;

	// ========================================
	// Judge and scroll
	// ========================================

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			// Empty window means the press is ignored
			clr_mask[l] = rise[l] ? deepest_hit(track[l]) : '0;
			kept[l]     = track[l] & ~clr_mask[l];
			hit_d[l]    = |clr_mask[l];
			// Falls off the bottom on a frame tick
			miss_d[l]   = frame_tick & kept[l][TRACK_DEPTH-1];
			if (frame_tick) begin
				track_d[l] = {kept[l][TRACK_DEPTH-2:0], 1'b0};
			end else begin
				track_d[l] = kept[l];
			end
			// New arrows enter at the top
			track_d[l][0] = track_d[l][0] | (arrows_valid & arrows[l]);
		end
	end

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			track <= '0;
			judge <= '0;
		end else begin
			track <= track_d;
			judge <= '{hit: hit_d, miss: miss_d};
		end
	end

endmodule

`default_nettype wire

// ==== logic/chart_fetch.sv ====
// Step-chart reader, paced asynchronous SRAM reads with end-of-chart detection
`default_nettype none

module chart_fetch (
	input  logic                               Clk,
	input  logic                               arst_n,
	input  logic                               start,
	input  logic                               frame_tick,
	input  logic [rhythm_pkg::SRAM_DATA_W-1:0] sram_dq,
	output logic [rhythm_pkg::SRAM_ADDR_W-1:0] sram_addr,
	output rhythm_pkg::sram_ctrl_t             sram_ctrl,
	output rhythm_pkg::lane_mask_t             arrows,
	output logic                               arrows_valid,
	output logic                               chart_done
);
	import rhythm_pkg::*;

	fetch_state_t           state;
	logic [FRAME_CNT_W-1:0] frame_cnt;
	logic [WAIT_CNT_W-1:0]  wait_cnt;
	// High while the SRAM is being read
	logic                   rd_q;
	logic [SRAM_DATA_W-1:0] word_q;
	logic                   step_due;
	logic                   wait_done;
	logic                   latch_now;

	// Last frame of a chart step
	assign step_due  = frame_tick && (frame_cnt == FRAME_CNT_W'(STEP_FRAMES - 1));
	assign wait_done = (wait_cnt == WAIT_CNT_W'(SRAM_WAIT - 1));
	assign latch_now = (state == FETCH_READ) && wait_done;

	// Read only, both bytes, CE follows OE
	assign sram_ctrl = '{ce_n: ~rd_q, oe_n: ~rd_q, we_n: 1'b1, ub_n: 1'b0, lb_n: 1'b0};

	// ========================================
	// Frame divider, replaces chart clock
	// ========================================

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_cnt <= '0;
		end else if (start) begin
			frame_cnt <= '0;
		end else if (frame_tick) begin
			frame_cnt <= step_due ? '0 : frame_cnt + 1'b1;
		end
	end

	// ========================================
	// Fetch FSM
	// ========================================

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= FETCH_IDLE;
			sram_addr    <= '0;
			wait_cnt     <= '0;
			rd_q         <= 1'b0;
			arrows_valid <= 1'b0;
			chart_done   <= 1'b0;
		end else begin
			// Valid is a single-cycle pulse
			arrows_valid <= 1'b0;
			if (start) begin
				// Restart at word 0, read it right away
				state      <= FETCH_READ;
				sram_addr  <= '0;
				wait_cnt   <= '0;
				rd_q       <= 1'b1;
				chart_done <= 1'b0;
			end else begin
				unique case (state)
					FETCH_IDLE: begin
						state <= FETCH_IDLE;
					end
					FETCH_WAIT_STEP: begin
						// Next word on every STEP_FRAMES-th tick
						if (step_due) begin
							state     <= FETCH_READ;
							sram_addr <= sram_addr + 1'b1;
							wait_cnt  <= '0;
							rd_q      <= 1'b1;
						end
					end
					FETCH_READ: begin
						// Hold address and OE for SRAM_WAIT clocks
						if (wait_done) begin
							state <= FETCH_LATCH;
							rd_q  <= 1'b0;
						end else begin
							wait_cnt <= wait_cnt + 1'b1;
						end
					end
					FETCH_LATCH: begin
						// End word gives no arrows and stops
						if (word_q[END_BIT]) begin
							chart_done <= 1'b1;
							state      <= FETCH_DONE;
						end else begin
							arrows_valid <= 1'b1;
							state        <= FETCH_WAIT_STEP;
						end
					end
					FETCH_DONE: begin
						state <= FETCH_DONE;
					end
					default: begin
						state <= FETCH_IDLE;
					end
				endcase
			end
		end
	end

	// Word capture at the end of the OE window
	always_ff @(posedge Clk) begin
		if (latch_now) begin
			word_q <= sram_dq;
		end
		if (state == FETCH_LATCH) begin
			arrows <= word_q[NUM_LANES-1:0];
		end
	end

endmodule

`default_nettype wire

// ==== logic/rhythm_pkg.sv ====
// Rhythm game constants, lane mask, SRAM strobes, judgement, display and fetch state types
`default_nettype none

package rhythm_pkg;

	// ========================================
	// Lane geometry
	// ========================================

	// Four arrow lanes, left to right
	localparam int NUM_LANES   = 4;
	// Positions per lane, 0 at the top
	localparam int TRACK_DEPTH = 8;
	// Bottom positions where a press counts
	localparam int HIT_WINDOW  = 2;

	// ========================================
	// Chart SRAM
	// ========================================

	localparam int SRAM_ADDR_W = 20;
	localparam int SRAM_DATA_W = 16;
	// End-of-chart marker bit in a chart word
	localparam int END_BIT     = 15;

	// Frame ticks per chart step
	localparam int STEP_FRAMES = 4;
	// Clocks with OE low before the word is taken
	localparam int SRAM_WAIT   = 2;

	// Counter widths for the fetcher
	localparam int FRAME_CNT_W = $clog2(STEP_FRAMES + 1);
	localparam int WAIT_CNT_W  = $clog2(SRAM_WAIT + 1);

	// ========================================
	// Score and display
	// ========================================

	localparam int SCORE_W     = 16;
	localparam int HIT_POINTS  = 10;
	localparam int MISS_POINTS = 5;
	// Headroom for the add before saturation
	localparam int SCORE_SUM_W = SCORE_W + 8;
	// Enough bits to count every lane at once
	localparam int LANE_CNT_W  = $clog2(NUM_LANES + 1);
	localparam logic [SCORE_W-1:0] SCORE_MAX = '1;

	// One hex digit per score nibble
	localparam int NUM_DIGITS  = 4;
	localparam int SEG_W       = 7;

	// One bit per lane
	typedef logic [NUM_LANES-1:0] lane_mask_t;

	// Active-low SRAM strobes
	typedef struct packed {
		logic ce_n;
		logic oe_n;
		logic we_n;
		logic ub_n;
		logic lb_n;
	} sram_ctrl_t;

	// Per-lane one-cycle judgement pulses
	typedef struct packed {
		lane_mask_t hit;
		lane_mask_t miss;
	} judge_t;

	// Digit 0 is the least significant nibble
	typedef logic [NUM_DIGITS-1:0][SEG_W-1:0] seg_digits_t;

	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_WAIT_STEP,
		FETCH_READ,
		FETCH_LATCH,
		FETCH_DONE
	} fetch_state_t;

endpackage

`default_nettype wire
